// ==== src/icache_pkg.sv ====
package icache_pkg;

    //////////////////////////////
    // address geometry
    //////////////////////////////

    // byte address from the core
    localparam int unsigned ADDR_W = 32;

    // 4 KiB, 2 ways, 32-byte lines
    localparam int unsigned LINE_BYTES = 32;
    localparam int unsigned NUM_SETS   = 64;

    // tag | index | offset split of an address
    localparam int unsigned OFFSET_W = 5;
    localparam int unsigned INDEX_W  = 6;
    localparam int unsigned TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    //////////////////////////////
    // refill burst
    //////////////////////////////

    // one 64-bit beat per AXI transfer
    localparam int unsigned BEAT_W         = 64;
    localparam int unsigned BEATS_PER_LINE = LINE_BYTES * 8 / BEAT_W;
    localparam int unsigned BEAT_CNT_W     = $clog2(BEATS_PER_LINE);

    // ARLEN is beats minus one
    localparam logic [7:0] BURST_LEN  = 8'(BEATS_PER_LINE - 1);
    // ARSIZE 3 means 8 bytes per beat
    localparam logic [2:0] BURST_SIZE = 3'd3;

    //////////////////////////////
    // shared types
    //////////////////////////////

    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [INDEX_W-1:0]      index_t;

endpackage

// ==== src/line_ram.sv ====
module line_ram #(
    // payload held per entry, a full line by default
    parameter type payload_t = icache_pkg::line_t
) (
    input  logic               I_clk,
    input  logic               en,
    input  logic               we,
    input  icache_pkg::index_t addr,
    input  payload_t           wdata,
    output payload_t           rdata
);

    // one entry per set
    payload_t mem [icache_pkg::NUM_SETS];

    //////////////////////////////
    // single port access
    //////////////////////////////

    // write when we, else registered read
    // rdata valid the cycle after an enabled read
    always_ff @(posedge I_clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // enable comes from the controller FSM
    // X before the first reset edge is fine, never afterwards
    a_en_known: assert property (
        @(posedge I_clk)
        !$isunknown($past(en)) |-> !$isunknown(en)
    ) else $error("line_ram: en became unknown");

endmodule

// ==== src/tag_store.sv ====
module tag_store (
    input  logic                          I_clk,
    input  logic                          I_rst,
    input  logic [icache_pkg::ADDR_W-1:0] lookup_addr,
    input  logic                          alloc,
    input  logic [icache_pkg::ADDR_W-1:0] alloc_addr,
    output logic [1:0]                    way_hit,
    output logic                          victim_way
);

    // tag and valid per way and set
    icache_pkg::tag_t                tag_q   [2][icache_pkg::NUM_SETS];
    logic [icache_pkg::NUM_SETS-1:0] valid_q [2];

    // address fields
    icache_pkg::tag_t   lk_tag;
    icache_pkg::index_t lk_index;
    icache_pkg::tag_t   al_tag;
    icache_pkg::index_t al_index;

    assign lk_tag   = lookup_addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    assign lk_index = lookup_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign al_tag   = alloc_addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    assign al_index = alloc_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];

    //////////////////////////////
    // lookup
    //////////////////////////////

    // combinational compare of both ways in the set
    for (genvar w = 0; w < 2; w++) begin : g_hit
        assign way_hit[w] = valid_q[w][lk_index] &&
                            (tag_q[w][lk_index] == lk_tag);
    end

    // way 1 only when way 0 full and way 1 empty
    // otherwise way 0 gets replaced
    assign victim_way = valid_q[0][al_index] && !valid_q[1][al_index];

    //////////////////////////////
    // allocate
    //////////////////////////////

    // valid bits cleared by reset
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
        end else if (alloc) begin
            valid_q[victim_way][al_index] <= 1'b1;
        end
    end

    // tag written with the valid bit
    always_ff @(posedge I_clk) begin
        if (alloc) begin
            tag_q[victim_way][al_index] <= al_tag;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // controller only allocates after a miss, so a tag lives in one way only
    a_single_hit: assert property (
        @(posedge I_clk) disable iff (I_rst)
        !(&way_hit)
    ) else $error("tag_store: both ways hit");

endmodule

// ==== src/refill_unit.sv ====
module refill_unit (
    input  logic                          I_clk,
    input  logic                          I_rst,
    input  logic                          refill_start,
    input  logic [icache_pkg::ADDR_W-1:0] miss_addr,
    output logic [icache_pkg::ADDR_W-1:0] mem_araddr,
    output logic                          mem_arvalid,
    output logic [7:0]                    mem_arlen,
    output logic [2:0]                    mem_arsize,
    input  logic                          mem_arready,
    input  logic [icache_pkg::BEAT_W-1:0] mem_rdata,
    input  logic                          mem_rvalid,
    input  logic                          mem_rlast,
    output logic                          mem_rready,
    output icache_pkg::line_t             refill_line,
    output logic                          refill_done
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } state_t;

    state_t                            state;
    logic [icache_pkg::BEAT_CNT_W-1:0] beat_cnt;
    logic                              beat_fire;

    // fixed burst shape, one full line
    assign mem_arlen  = icache_pkg::BURST_LEN;
    assign mem_arsize = icache_pkg::BURST_SIZE;

    // AR up in ADDR, R accepted in DATA
    assign mem_arvalid = (state == ADDR);
    assign mem_rready  = (state == DATA);
    assign beat_fire   = mem_rvalid && mem_rready;

    //////////////////////////////
    // burst FSM
    //////////////////////////////

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state       <= IDLE;
            beat_cnt    <= '0;
            refill_done <= 1'b0;
        end else begin
            // done is a single pulse
            refill_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (refill_start) begin
                        state    <= ADDR;
                        beat_cnt <= '0;
                    end
                end
                // hold AR until the slave takes it
                ADDR: begin
                    if (mem_arready) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (beat_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (mem_rlast) begin
                            state       <= IDLE;
                            refill_done <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // line-aligned address, captured on start
    // beats shift in from the top, beat 0 ends at the bottom
    always_ff @(posedge I_clk) begin
        if (state == IDLE && refill_start) begin
            mem_araddr <= {miss_addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                           {icache_pkg::OFFSET_W{1'b0}}};
        end
        if (beat_fire) begin
            refill_line <= {mem_rdata,
                            refill_line[icache_pkg::LINE_BYTES*8-1:icache_pkg::BEAT_W]};
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    a_araddr_stable: assert property (
        @(posedge I_clk) disable iff (I_rst)
        mem_arvalid && !mem_arready |=> $stable(mem_araddr)
    ) else $error("refill_unit: araddr changed while waiting for arready");

    // slave must end the burst on the fourth beat, no earlier or later
    a_rlast_fourth: assert property (
        @(posedge I_clk) disable iff (I_rst)
        beat_fire |-> (mem_rlast ==
            (beat_cnt == icache_pkg::BEAT_CNT_W'(icache_pkg::BEATS_PER_LINE - 1)))
    ) else $error("refill_unit: rlast on wrong beat");

endmodule

// ==== src/icache_ctrl.sv ====
module icache_ctrl (
    input  logic                          I_clk,
    input  logic                          I_rst,
    input  logic                          cpu_req,
    input  logic [icache_pkg::ADDR_W-1:0] cpu_addr,
    output logic                          cpu_ready,
    output logic                          cpu_rvalid,
    output logic [31:0]                   cpu_inst,
    input  logic [1:0]                    way_hit,
    input  logic                          victim_way,
    output logic                          alloc,
    output logic [icache_pkg::ADDR_W-1:0] req_addr,
    output logic                          refill_start,
    input  logic                          refill_done,
    input  icache_pkg::line_t             refill_line,
    output logic                          way0_en,
    output logic                          way0_we,
    output logic                          way1_en,
    output logic                          way1_we,
    output icache_pkg::index_t            ram_addr,
    output icache_pkg::line_t             ram_wdata,
    input  icache_pkg::line_t             way0_rdata,
    input  icache_pkg::line_t             way1_rdata
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT_DATA,
        REFILL,
        ALLOC,
        RESP
    } state_t;

    state_t            state;
    logic              hit_way_q;
    logic              hit;
    logic [2:0]        word_sel;
    icache_pkg::line_t src_line;

    assign hit      = |way_hit;
    // word within line, byte bits ignored
    assign word_sel = req_addr[icache_pkg::OFFSET_W-1:2];

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state     <= IDLE;
            req_addr  <= '0;
            hit_way_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu_req) begin
                        req_addr <= cpu_addr;
                        state    <= LOOKUP;
                    end
                end
                // tag compare is combinational on req_addr
                LOOKUP: begin
                    hit_way_q <= way_hit[1];
                    state     <= hit ? HIT_DATA : REFILL;
                end
                HIT_DATA: state <= RESP;
                REFILL: begin
                    if (refill_done) begin
                        state <= ALLOC;
                    end
                end
                ALLOC:   state <= RESP;
                RESP:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign cpu_ready    = (state == IDLE);
    assign cpu_rvalid   = (state == RESP);
    assign refill_start = (state == LOOKUP) && !hit;
    assign alloc        = (state == ALLOC);

    //////////////////////////////
    // RAM control
    //////////////////////////////

    // read hit way in LOOKUP, write victim way in ALLOC
    assign way0_en   = ((state == LOOKUP) && way_hit[0]) || (alloc && !victim_way);
    assign way1_en   = ((state == LOOKUP) && way_hit[1]) || (alloc && victim_way);
    assign way0_we   = alloc && !victim_way;
    assign way1_we   = alloc && victim_way;
    assign ram_addr  = req_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign ram_wdata = refill_line;

    //////////////////////////////
    // response word
    //////////////////////////////

    // refill line in ALLOC, else the way read last cycle
    assign src_line = (state == ALLOC) ? refill_line :
                      (hit_way_q ? way1_rdata : way0_rdata);

    always_ff @(posedge I_clk) begin
        if (state == HIT_DATA || state == ALLOC) begin
            cpu_inst <= src_line[{word_sel, 5'b0} +: 32];
        end
    end

    // one response per request, CPU waits before the next
    a_rvalid_pulse: assert property (
        @(posedge I_clk) disable iff (I_rst)
        cpu_rvalid |=> !cpu_rvalid
    ) else $error("icache_ctrl: cpu_rvalid held two cycles");

endmodule

// ==== src/icache_top.sv ====
module icache_top (
    input  logic                          I_clk,
    input  logic                          I_rst,
    // CPU port
    input  logic                          cpu_req,
    input  logic [icache_pkg::ADDR_W-1:0] cpu_addr,
    output logic                          cpu_ready,
    output logic                          cpu_rvalid,
    output logic [31:0]                   cpu_inst,
    // AXI4 read channel
    output logic [icache_pkg::ADDR_W-1:0] mem_araddr,
    output logic                          mem_arvalid,
    output logic [7:0]                    mem_arlen,
    output logic [2:0]                    mem_arsize,
    input  logic                          mem_arready,
    input  logic [icache_pkg::BEAT_W-1:0] mem_rdata,
    input  logic                          mem_rvalid,
    input  logic                          mem_rlast,
    output logic                          mem_rready
);

    // tag store
    logic [1:0]                    way_hit;
    logic                          victim_way;
    logic                          alloc;
    logic [icache_pkg::ADDR_W-1:0] req_addr;
    // refill
    logic                          refill_start;
    logic                          refill_done;
    icache_pkg::line_t             refill_line;
    // way RAMs
    logic                          way0_en;
    logic                          way0_we;
    logic                          way1_en;
    logic                          way1_we;
    icache_pkg::index_t            ram_addr;
    icache_pkg::line_t             ram_wdata;
    icache_pkg::line_t             way0_rdata;
    icache_pkg::line_t             way1_rdata;

    //////////////////////////////
    // control
    //////////////////////////////

    icache_ctrl u_ctrl (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .cpu_req      (cpu_req),
        .cpu_addr     (cpu_addr),
        .cpu_ready    (cpu_ready),
        .cpu_rvalid   (cpu_rvalid),
        .cpu_inst     (cpu_inst),
        .way_hit      (way_hit),
        .victim_way   (victim_way),
        .alloc        (alloc),
        .req_addr     (req_addr),
        .refill_start (refill_start),
        .refill_done  (refill_done),
        .refill_line  (refill_line),
        .way0_en      (way0_en),
        .way0_we      (way0_we),
        .way1_en      (way1_en),
        .way1_we      (way1_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .way0_rdata   (way0_rdata),
        .way1_rdata   (way1_rdata)
    );

    // lookup and allocate both use the latched request
    tag_store u_tags (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .lookup_addr (req_addr),
        .alloc       (alloc),
        .alloc_addr  (req_addr),
        .way_hit     (way_hit),
        .victim_way  (victim_way)
    );

    //////////////////////////////
    // memory side
    //////////////////////////////

    refill_unit u_refill (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .refill_start (refill_start),
        .miss_addr    (req_addr),
        .mem_araddr   (mem_araddr),
        .mem_arvalid  (mem_arvalid),
        .mem_arlen    (mem_arlen),
        .mem_arsize   (mem_arsize),
        .mem_arready  (mem_arready),
        .mem_rdata    (mem_rdata),
        .mem_rvalid   (mem_rvalid),
        .mem_rlast    (mem_rlast),
        .mem_rready   (mem_rready),
        .refill_line  (refill_line),
        .refill_done  (refill_done)
    );

    // data arrays, shared address and write data
    line_ram #(.payload_t(icache_pkg::line_t)) u_way0_ram (
        .I_clk (I_clk),
        .en    (way0_en),
        .we    (way0_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (way0_rdata)
    );

    line_ram #(.payload_t(icache_pkg::line_t)) u_way1_ram (
        .I_clk (I_clk),
        .en    (way1_en),
        .we    (way1_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (way1_rdata)
    );

endmodule

// ==== dv/axi_mem_model.sv ====
module axi_mem_model #(
    parameter int unsigned SEED = 32'hd0ea6dd7
) (
    input  logic        I_clk,
    input  logic        I_rst,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    input  logic [7:0]  arlen,
    output logic        arready,
    output logic [63:0] rdata,
    output logic        rvalid,
    output logic        rlast,
    input  logic        rready
);
    timeunit 1ns;
    timeprecision 1ps;

    integer      seed;
    logic        busy;
    logic [31:0] base_q;
    logic [7:0]  len_q;
    logic [7:0]  beat;
    logic [31:0] beat_addr;

    // byte address of the beat being served
    assign beat_addr = base_q + {beat, 3'b000};

    // word at byte address a, low two bits dropped
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_c3c3;
    endfunction

    // outputs quiet before the first reset edge
    initial begin
        seed    = SEED;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
    end

    //////////////////////////////
    // read slave
    //////////////////////////////

    // about one cycle in four stalls, on AR and on R
    always @(posedge I_clk) begin
        if (I_rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            busy    <= 1'b0;
            beat    <= '0;
            base_q  <= '0;
            len_q   <= '0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                busy    <= 1'b1;
                base_q  <= araddr;
                len_q   <= arlen;
                beat    <= '0;
                arready <= 1'b0;
            end else begin
                arready <= ($random(seed) & 3) != 0;
            end
        end else if (rvalid && rready) begin
            // beat taken, next one no earlier than the cycle after
            rvalid <= 1'b0;
            rlast  <= 1'b0;
            if (rlast) begin
                busy <= 1'b0;
            end else begin
                beat <= beat + 1'b1;
            end
        end else if (!rvalid && (($random(seed) & 3) != 0)) begin
            // little endian, lower word in the low half
            rvalid <= 1'b1;
            rdata  <= {mem_word(beat_addr + 32'd4), mem_word(beat_addr)};
            rlast  <= (beat == len_q);
        end
    end

endmodule

// ==== dv/icache_tb.sv ====
module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SEED_INIT   = 32'hd0ea6dd7;
    localparam int          TIMEOUT_CYC = 2000;
    // cycles between the accepting edge and the response
    localparam int          HIT_LATENCY = 2;

    logic        I_clk = 1'b0;
    logic        I_rst;
    logic        cpu_req;
    logic [31:0] cpu_addr;
    logic        cpu_ready;
    logic        cpu_rvalid;
    logic [31:0] cpu_inst;
    logic [31:0] mem_araddr;
    logic        mem_arvalid;
    logic [7:0]  mem_arlen;
    logic [2:0]  mem_arsize;
    logic        mem_arready;
    logic [63:0] mem_rdata;
    logic        mem_rvalid;
    logic        mem_rlast;
    logic        mem_rready;

    // reference tags and valid bits, way by set
    logic [20:0] model_tag   [2][64];
    logic        model_valid [2][64];

    // one entry per accepted request
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_word_q [$];
    bit          exp_miss_q [$];
    int          accept_cyc_q [$];
    int          accept_ar_q [$];

    integer      seed;
    logic [31:0] cur_line;
    bit          timed_out = 1'b0;
    // burst accepted on AR and its last beat not yet taken
    bit          burst_open = 1'b0;
    int          cycle_cnt = 0;
    int          ar_cnt = 0;
    int          exp_ar_total = 0;
    int          resp_checked = 0;
    int          data_err = 0;
    int          ctrl_err = 0;
    int          timeout_err = 0;

    always #10 I_clk = ~I_clk;

    icache_top u_dut (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .cpu_req     (cpu_req),
        .cpu_addr    (cpu_addr),
        .cpu_ready   (cpu_ready),
        .cpu_rvalid  (cpu_rvalid),
        .cpu_inst    (cpu_inst),
        .mem_araddr  (mem_araddr),
        .mem_arvalid (mem_arvalid),
        .mem_arlen   (mem_arlen),
        .mem_arsize  (mem_arsize),
        .mem_arready (mem_arready),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rlast   (mem_rlast),
        .mem_rready  (mem_rready)
    );

    axi_mem_model #(.SEED(SEED_INIT)) u_mem (
        .I_clk   (I_clk),
        .I_rst   (I_rst),
        .araddr  (mem_araddr),
        .arvalid (mem_arvalid),
        .arlen   (mem_arlen),
        .arready (mem_arready),
        .rdata   (mem_rdata),
        .rvalid  (mem_rvalid),
        .rlast   (mem_rlast),
        .rready  (mem_rready)
    );

    //////////////////////////////
    // reference model
    //////////////////////////////

    // tag 21 bits, set 6 bits, offset 5 bits
    function automatic logic [31:0] make_addr(input logic [20:0] tag, input logic [5:0] idx,
                                              input logic [4:0] off);
        return {tag, idx, off};
    endfunction

    // updates the model, returns the expected word and whether a burst follows
    function automatic logic [31:0] predict_access(input logic [31:0] addr, output bit miss);
        logic [20:0] tag;
        logic [5:0]  idx;
        int          way;
        tag  = addr[31:11];
        idx  = addr[10:5];
        miss = 1'b1;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][idx] && model_tag[w][idx] == tag) begin
                miss = 1'b0;
            end
        end
        // way 1 only if way 0 full and way 1 empty
        if (miss) begin
            way = (model_valid[0][idx] && !model_valid[1][idx]) ? 1 : 0;
            model_valid[way][idx] = 1'b1;
            model_tag[way][idx]   = tag;
        end
        return {addr[31:2], 2'b00} ^ 32'h5a5a_c3c3;
    endfunction

    //////////////////////////////
    // compare
    //////////////////////////////

    task automatic note_timeout(input string what);
        timeout_err++;
        timed_out = 1'b1;
        $display("timeout: %s", what);
    endtask

    task automatic check_ar();
        assert (mem_araddr === cur_line) else begin
            ctrl_err++;
            $display("[FAIL] mem_araddr: got %h expected %h", mem_araddr, cur_line);
        end
        assert (mem_arlen === 8'd3) else begin
            ctrl_err++;
            $display("[FAIL] mem_arlen: got %h expected %h", mem_arlen, 8'd3);
        end
        assert (mem_arsize === 3'd3) else begin
            ctrl_err++;
            $display("[FAIL] mem_arsize: got %h expected %h", mem_arsize, 3'd3);
        end
    endtask

    task automatic check_response();
        logic [31:0] addr;
        logic [31:0] word;
        bit          miss;
        int          lat;
        int          bursts;
        if (exp_word_q.size() == 0) begin
            ctrl_err++;
            $display("cpu_rvalid rose with no request outstanding");
            return;
        end
        addr   = exp_addr_q.pop_front();
        word   = exp_word_q.pop_front();
        miss   = exp_miss_q.pop_front();
        // rvalid seen at this edge was raised by the edge before
        lat    = cycle_cnt - accept_cyc_q.pop_front() - 1;
        bursts = ar_cnt - accept_ar_q.pop_front();
        resp_checked++;
        assert (cpu_inst === word) else begin
            data_err++;
            $display("[FAIL] cpu_inst @%h: got %h expected %h", addr, cpu_inst, word);
        end
        assert (bursts == int'(miss)) else begin
            ctrl_err++;
            $display("[FAIL] mem_arvalid bursts @%h: got %h expected %h", addr, bursts, miss);
        end
        assert (miss || lat == HIT_LATENCY) else begin
            ctrl_err++;
            $display("[FAIL] cpu_rvalid latency @%h: got %h expected %h", addr, lat, HIT_LATENCY);
        end
    endtask

    always @(posedge I_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!I_rst && mem_arvalid && mem_arready) begin
            ar_cnt     <= ar_cnt + 1;
            burst_open <= 1'b1;
            check_ar();
        end
        if (!I_rst && mem_rvalid && mem_rready && mem_rlast) begin
            burst_open <= 1'b0;
        end
        // rready only between AR acceptance and the last beat
        if (!I_rst) begin
            assert (!mem_rready || burst_open) else begin
                ctrl_err++;
                $display("[FAIL] mem_rready: got %h expected %h", mem_rready, 1'b0);
            end
        end
        if (!I_rst && cpu_rvalid) begin
            check_response();
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // one request, held until accepted, then wait for its response
    task automatic cpu_access(input logic [31:0] addr);
        bit          miss;
        logic [31:0] word;
        int          n;
        if (timed_out) begin
            return;
        end
        cpu_req  <= 1'b1;
        cpu_addr <= addr;
        for (n = 0; n < TIMEOUT_CYC; n++) begin
            @(posedge I_clk);
            if (cpu_ready) begin
                break;
            end
        end
        if (n == TIMEOUT_CYC) begin
            note_timeout("request never accepted");
            return;
        end
        // accepted at this edge
        word = predict_access(addr, miss);
        exp_addr_q.push_back(addr);
        exp_word_q.push_back(word);
        exp_miss_q.push_back(miss);
        accept_cyc_q.push_back(cycle_cnt);
        accept_ar_q.push_back(ar_cnt);
        if (miss) begin
            exp_ar_total++;
        end
        cur_line = {addr[31:5], 5'b0};
        cpu_req <= 1'b0;
        for (n = 0; n < TIMEOUT_CYC; n++) begin
            @(posedge I_clk);
            if (cpu_rvalid) begin
                break;
            end
        end
        if (n == TIMEOUT_CYC) begin
            note_timeout("no response after an accepted request");
        end
    endtask

    task automatic check_idle();
        repeat (3) begin
            @(posedge I_clk);
            assert (!cpu_rvalid && !mem_arvalid && cpu_ready) else begin
                ctrl_err++;
                $display("[FAIL] cpu_rvalid/mem_arvalid/cpu_ready: got %h/%h/%h expected 0/0/1",
                         cpu_rvalid, mem_arvalid, cpu_ready);
            end
        end
    endtask

    // every word of one line, byte bits set to check they are ignored
    task automatic cold_line();
        logic [31:0] base;
        base = make_addr(21'h00011, 6'd2, 5'd0);
        for (int i = 0; i < 8; i++) begin
            cpu_access(base + 32'(4 * i + i % 4));
        end
        for (int i = 7; i >= 0; i--) begin
            cpu_access(base + 32'(4 * i));
        end
    endtask

    // fill both ways of set 5, then a third tag evicts way 0
    task automatic two_way();
        cpu_access(make_addr(21'h00100, 6'd5, 5'd0));
        cpu_access(make_addr(21'h00200, 6'd5, 5'd4));
        cpu_access(make_addr(21'h00100, 6'd5, 5'd8));
        cpu_access(make_addr(21'h00200, 6'd5, 5'd12));
        cpu_access(make_addr(21'h00300, 6'd5, 5'd16));
        cpu_access(make_addr(21'h00100, 6'd5, 5'd20));
        cpu_access(make_addr(21'h00200, 6'd5, 5'd24));
        cpu_access(make_addr(21'h00300, 6'd5, 5'd28));
    endtask

    // eight tags over three sets, so misses stay frequent
    task automatic random_run();
        int unsigned r;
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            cpu_access(make_addr({18'h00001, r[2:0]}, 6'd8 + 6'(r[9:4] % 3), r[20:16]));
        end
    endtask

    initial begin
        I_rst    = 1'b1;
        cpu_req  = 1'b0;
        cpu_addr = '0;
        seed     = SEED_INIT;
        cur_line = '0;
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < 64; s++) begin
                model_valid[w][s] = 1'b0;
                model_tag[w][s]   = '0;
            end
        end
        repeat (4) @(posedge I_clk);
        I_rst <= 1'b0;
        check_idle();
        cold_line();
        two_way();
        random_run();
        repeat (4) @(posedge I_clk);
        assert (ar_cnt == exp_ar_total) else begin
            ctrl_err++;
            $display("[FAIL] mem_arvalid total bursts: got %h expected %h", ar_cnt, exp_ar_total);
        end
        assert (exp_word_q.size() == 0) else begin
            ctrl_err++;
            $display("requests left without a response at the end of the run");
        end
        $display("errors: data %0d, control %0d, timeout %0d (%0d responses checked)",
                 data_err, ctrl_err, timeout_err, resp_checked);
        if (data_err + ctrl_err + timeout_err == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/icache_pkg.sv
src/line_ram.sv
src/tag_store.sv
src/refill_unit.sv
src/icache_ctrl.sv
src/icache_top.sv
dv/axi_mem_model.sv
dv/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - src/icache_pkg.sv
  - src/line_ram.sv
  - src/tag_store.sv
  - src/refill_unit.sv
  - src/icache_ctrl.sv
  - src/icache_top.sv
  - target: simulation
    files:
      - dv/axi_mem_model.sv
      - dv/icache_tb.sv
